// File: src.f
+incdir+src
src/rap_pkg.sv
src/meta_ram.sv
src/rpct.sv
src/ras.sv
src/return_predictor.sv
sim/tb_return_predictor.sv

// File: run.sh
#!/bin/sh
# build and run the return predictor testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f src.f \
    --top-module tb_return_predictor --Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Errors found" "$LOG"; then
    echo "FAIL"
    exit 1
fi

echo "PASS"
exit 0

// File: sim/tb_return_predictor.sv
`timescale 1ns/100ps

`include "rap_cfg.svh"

module tb_return_predictor;

    localparam int PERIOD = 4;
    localparam int NSETS = `RAP_SETS;
    localparam int NWAYS = `RAP_WAYS;
    localparam int DEPTH = `RAP_RAS_DEPTH;
    localparam int RESET_CYCLES = 8;
    localparam int CLEAR_LIMIT = 4 * `RAP_SETS;
    localparam int DIRECTED_CYCLES = 100;
    localparam int RAND_CYCLES = 2000;
    localparam int WATCHDOG_NS =
        (RESET_CYCLES + CLEAR_LIMIT + DIRECTED_CYCLES + RAND_CYCLES) * PERIOD + 200;
    localparam int POOL_N = 6;

    logic clk;
    logic arst_n;
    rap_pkg::fetch_req_t fetch;
    rap_pkg::train_t train;
    rap_pkg::pred_t pred;
    logic ready;

    int pred_errors;
    int ready_errors;
    int other_errors;
    logic last_ready;

    // reference model state
    logic m_valid [NSETS][NWAYS];
    rap_pkg::tag_t m_tag [NSETS][NWAYS];
    rap_pkg::way_t m_lru [NSETS];
    rap_pkg::addr_t m_stack [$];
    int m_clear_left;

    // return bundles, three share set 2
    rap_pkg::addr_t ret_pool [POOL_N];

    return_predictor i_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .fetch  (fetch),
        .train  (train),
        .pred   (pred),
        .ready  (ready)
    );

    initial clk = 1'b0;
    always #(PERIOD / 2) clk = ~clk;

    function automatic rap_pkg::addr_t make_pc(rap_pkg::tag_t tag, rap_pkg::index_t idx);
        return {tag, idx, 3'b000};
    endfunction

    function automatic rap_pkg::fetch_req_t make_fetch(logic valid, rap_pkg::addr_t pc);
        rap_pkg::fetch_req_t f;
        f.valid = valid;
        f.pc = pc;
        return f;
    endfunction

    function automatic rap_pkg::train_t make_train(rap_pkg::train_op_e op, rap_pkg::addr_t pc);
        rap_pkg::train_t t;
        t.op = op;
        t.pc = pc;
        return t;
    endfunction

    // either instruction slot of a pooled bundle
    function automatic rap_pkg::addr_t pick_pool_pc();
        return ret_pool[$urandom_range(POOL_N - 1, 0)] | ($urandom() & 32'h4);
    endfunction

    function automatic rap_pkg::fetch_req_t random_fetch();
        return make_fetch($urandom_range(3, 0) != 0, pick_pool_pc());
    endfunction

    function automatic rap_pkg::train_t random_train();
        int unsigned sel;
        sel = $urandom_range(9, 0);
        if (sel < 3) begin
            return make_train(rap_pkg::train_call, $urandom() & 32'hffff_fffc);
        end else if (sel < 6) begin
            return make_train(rap_pkg::train_ret, pick_pool_pc());
        end
        return make_train(rap_pkg::train_none, '0);
    endfunction

    function automatic void reset_model();
        for (int s = 0; s < NSETS; s++) begin
            for (int w = 0; w < NWAYS; w++) begin
                m_valid[s][w] = 1'b0;
                m_tag[s][w] = '0;
            end
            m_lru[s] = '0;
        end
        m_stack.delete();
        m_clear_left = NSETS;
    endfunction

    function automatic logic model_ready();
        return m_clear_left == 0;
    endfunction

    // matching way in a set, -1 when none
    function automatic int find_way(rap_pkg::index_t idx, rap_pkg::tag_t tag);
        int found;
        found = -1;
        for (int w = 0; w < NWAYS; w++) begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag) begin
                found = w;
            end
        end
        return found;
    endfunction

    function automatic rap_pkg::pred_t model_pred(rap_pkg::fetch_req_t f);
        rap_pkg::pred_t p;
        int w;
        p.valid = 1'b0;
        p.target = '0;
        w = find_way(rap_pkg::bundle_index(f.pc), rap_pkg::bundle_tag(f.pc));
        if (f.valid && w >= 0 && model_ready() && m_stack.size() > 0) begin
            p.valid = 1'b1;
            p.target = m_stack[$];
        end
        return p;
    endfunction

    // everything decided from the state before the edge
    function automatic void update_model(rap_pkg::fetch_req_t f, rap_pkg::train_t t);
        rap_pkg::index_t li;
        rap_pkg::index_t ri;
        rap_pkg::tag_t rt;
        rap_pkg::way_t victim;
        int hw;
        int dw;
        li = rap_pkg::bundle_index(f.pc);
        ri = rap_pkg::bundle_index(t.pc);
        rt = rap_pkg::bundle_tag(t.pc);
        hw = find_way(li, rap_pkg::bundle_tag(f.pc));
        dw = find_way(ri, rt);
        victim = m_lru[ri];
        if (model_ready()) begin
            // lookup steers the lru even without fetch.valid
            if (hw >= 0) begin
                m_lru[li] = ~rap_pkg::way_t'(hw);
            end
            if (t.op == rap_pkg::train_ret && dw < 0) begin
                m_valid[ri][victim] = 1'b1;
                m_tag[ri][victim] = rt;
                m_lru[ri] = ~victim;
            end
        end
        if (t.op == rap_pkg::train_call) begin
            if (m_stack.size() == DEPTH) begin
                void'(m_stack.pop_front());
            end
            m_stack.push_back(t.pc + 32'd8);
        end else if (t.op == rap_pkg::train_ret && m_stack.size() > 0) begin
            void'(m_stack.pop_back());
        end
        if (m_clear_left > 0) begin
            m_clear_left--;
        end
    endfunction

    task automatic check_pred(input rap_pkg::pred_t got, input rap_pkg::pred_t exp);
        if (got.valid !== exp.valid) begin
            pred_errors++;
            $display("** Error: pred.valid got %h expected %h at %0t",
                     got.valid, exp.valid, $time);
        end else if (exp.valid && got.target !== exp.target) begin
            pred_errors++;
            $display("** Error: pred.target got %h expected %h at %0t",
                     got.target, exp.target, $time);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        if (got !== exp) begin
            ready_errors++;
            $display("** Error: ready got %h expected %h at %0t", got, exp, $time);
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic step(input rap_pkg::fetch_req_t f, input rap_pkg::train_t t);
        rap_pkg::pred_t exp_pred;
        logic exp_ready;
        fetch = f;
        train = t;
        exp_pred = model_pred(f);
        exp_ready = model_ready();
        #1;
        last_ready = ready;
        check_pred(pred, exp_pred);
        check_ready(ready, exp_ready);
        @(posedge clk);
        update_model(f, t);
        @(negedge clk);
    endtask

    task automatic fetch_bundle(input rap_pkg::addr_t pc);
        step(make_fetch(1'b1, pc), make_train(rap_pkg::train_none, '0));
    endtask

    task automatic resolve_call(input rap_pkg::addr_t pc);
        step(make_fetch(1'b0, '0), make_train(rap_pkg::train_call, pc));
    endtask

    task automatic resolve_return(input rap_pkg::addr_t pc);
        step(make_fetch(1'b0, '0), make_train(rap_pkg::train_ret, pc));
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, the run did not complete", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

    initial begin
        int unsigned seed_dummy;
        int clear_cycles;
        seed_dummy = $urandom(32'hab8a300a);
        pred_errors = 0;
        ready_errors = 0;
        other_errors = 0;
        last_ready = 1'b0;
        arst_n = 1'b0;
        fetch = '0;
        train = make_train(rap_pkg::train_none, '0);
        ret_pool[0] = make_pc(rap_pkg::tag_t'('h11), rap_pkg::index_t'(2));
        ret_pool[1] = make_pc(rap_pkg::tag_t'('h22), rap_pkg::index_t'(2));
        ret_pool[2] = make_pc(rap_pkg::tag_t'('h33), rap_pkg::index_t'(2));
        ret_pool[3] = make_pc(rap_pkg::tag_t'('h11), rap_pkg::index_t'(5));
        ret_pool[4] = make_pc(rap_pkg::tag_t'('h44), rap_pkg::index_t'(5));
        ret_pool[5] = make_pc(rap_pkg::tag_t'('h55), rap_pkg::index_t'(0));
        reset_model();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        // clearing sweep, stack still trains
        clear_cycles = 0;
        last_ready = 1'b0;
        while (!last_ready && clear_cycles <= CLEAR_LIMIT) begin
            step(random_fetch(), random_train());
            if (!last_ready) begin
                clear_cycles++;
            end
        end
        if (!last_ready) begin
            other_errors++;
            $display("ready never rose within %0d cycles after reset", CLEAR_LIMIT);
        end else if (clear_cycles != NSETS) begin
            other_errors++;
            $display("clearing sweep took %0d cycles instead of %0d", clear_cycles, NSETS);
        end

        // latest unreturned call
        resolve_call(32'h0000_2000);
        resolve_call(32'h0000_3000);
        resolve_return(ret_pool[3]);
        fetch_bundle(ret_pool[3]);
        fetch_bundle(ret_pool[3] | 32'h4);

        // overflow, then drain past empty
        for (int i = 0; i < DEPTH + 2; i++) begin
            resolve_call(32'h0001_0000 + 32'(i * 16));
        end
        for (int i = 0; i < DEPTH + 3; i++) begin
            resolve_return(ret_pool[4]);
            fetch_bundle(ret_pool[4]);
        end

        // three bundles competing for set 2
        for (int i = 0; i < 4; i++) begin
            resolve_call(32'h0002_0000 + 32'(i * 32));
        end
        resolve_return(ret_pool[0]);
        resolve_return(ret_pool[1]);
        fetch_bundle(ret_pool[0]);
        resolve_return(ret_pool[2]);
        fetch_bundle(ret_pool[1]);
        fetch_bundle(ret_pool[0]);
        fetch_bundle(ret_pool[2]);

        // known return again, no second entry
        resolve_call(32'h0003_0000);
        resolve_call(32'h0003_0100);
        resolve_return(ret_pool[0]);
        resolve_return(ret_pool[0] | 32'h4);
        fetch_bundle(ret_pool[2]);
        fetch_bundle(ret_pool[0]);

        repeat (RAND_CYCLES) begin
            step(random_fetch(), random_train());
        end

        $display("pred errors %0d, ready errors %0d, other errors %0d",
                 pred_errors, ready_errors, other_errors);
        if (pred_errors + ready_errors + other_errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: src/return_predictor.sv
`timescale 1ns/100ps

module return_predictor (
    input logic clk,
    input logic arst_n,
    input rap_pkg::fetch_req_t fetch,
    input rap_pkg::train_t train,
    output rap_pkg::pred_t pred,
    output logic ready
);

    logic is_call;
    logic is_ret;
    logic hit;
    logic empty;
    rap_pkg::addr_t link_addr;
    rap_pkg::addr_t top;

    // resolved branches from execute
    assign is_call = (train.op == rap_pkg::train_call);
    assign is_ret = (train.op == rap_pkg::train_ret);

    // return lands after the delay slot
    assign link_addr = train.pc + rap_pkg::addr_t'(8);

    rpct u_rpct (
        .clk       (clk),
        .arst_n    (arst_n),
        .lookup_pc (fetch.pc),
        .record    (is_ret),
        .record_pc (train.pc),
        .hit       (hit),
        .ready     (ready)
    );

    ras u_ras (
        .clk       (clk),
        .arst_n    (arst_n),
        .push      (is_call),
        .push_addr (link_addr),
        .pop       (is_ret),
        .top       (top),
        .empty     (empty)
    );

    // same-cycle prediction from the asynchronous reads
    always_comb begin
        pred.valid = fetch.valid && hit && !empty && ready;
        pred.target = top;
    end

endmodule

// File: src/ras.sv
`timescale 1ns/100ps

`include "rap_cfg.svh"

module ras (
    input logic clk,
    input logic arst_n,
    input logic push,
    input rap_pkg::addr_t push_addr,
    input logic pop,
    output rap_pkg::addr_t top,
    output logic empty
);

    localparam int PTR_W = $clog2(`RAP_RAS_DEPTH);
    localparam int CNT_W = $clog2(`RAP_RAS_DEPTH + 1);

    rap_pkg::addr_t stack [`RAP_RAS_DEPTH];

    // ptr names the entry on top, count saturates at depth
    logic [PTR_W-1:0] ptr;
    logic [PTR_W-1:0] ptr_inc;
    logic [PTR_W-1:0] ptr_dec;
    logic [CNT_W-1:0] count;
    logic full;

    assign ptr_inc = (ptr == PTR_W'(`RAP_RAS_DEPTH - 1)) ? '0 : ptr + 1'b1;
    assign ptr_dec = (ptr == '0) ? PTR_W'(`RAP_RAS_DEPTH - 1) : ptr - 1'b1;

    assign full = (count == CNT_W'(`RAP_RAS_DEPTH));
    assign empty = (count == '0);

    // pointer and occupancy
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ptr <= '0;
            count <= '0;
        end else if (push) begin
            ptr <= ptr_inc;
            if (!full) begin
                count <= count + 1'b1;
            end
        end else if (pop && !empty) begin
            ptr <= ptr_dec;
            count <= count - 1'b1;
        end
    end

    // when full the slot after top is the oldest entry
    always_ff @(posedge clk) begin
        if (push) begin
            stack[ptr_inc] <= push_addr;
        end
    end

    assign top = stack[ptr];

    // one training event per cycle from execute
    a_push_pop_excl: assert property (
        @(posedge clk) disable iff (!arst_n)
        !(push && pop)
    ) else $error("ras: push and pop in the same cycle");

endmodule

// File: src/rpct.sv
`timescale 1ns/100ps

`include "rap_cfg.svh"

module rpct (
    input logic clk,
    input logic arst_n,
    input rap_pkg::addr_t lookup_pc,
    input logic record,
    input rap_pkg::addr_t record_pc,
    output logic hit,
    output logic ready
);

    typedef enum logic {
        st_clear,
        st_run
    } init_state_e;

    init_state_e state;
    rap_pkg::index_t clr_idx;

    rap_pkg::index_t look_idx;
    rap_pkg::tag_t look_tag;
    rap_pkg::index_t rec_idx;
    rap_pkg::tag_t rec_tag;

    rap_pkg::set_meta_t rd_a;
    rap_pkg::set_meta_t rd_b;
    rap_pkg::set_meta_t merged;

    logic ram_we;
    rap_pkg::index_t ram_waddr;
    rap_pkg::set_meta_t ram_wdata;

    logic raw_hit;
    rap_pkg::way_t hit_way;
    logic dup;
    logic do_write;
    rap_pkg::way_t victim;

    // one bit per set, names the way to replace next
    logic [`RAP_SETS-1:0] plru;

    assign look_idx = rap_pkg::bundle_index(lookup_pc);
    assign look_tag = rap_pkg::bundle_tag(lookup_pc);
    assign rec_idx = rap_pkg::bundle_index(record_pc);
    assign rec_tag = rap_pkg::bundle_tag(record_pc);

    // post-reset sweep, one set per cycle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_clear;
            clr_idx <= '0;
        end else begin
            case (state)
                st_clear: begin
                    clr_idx <= clr_idx + 1'b1;
                    if (clr_idx == rap_pkg::index_t'(`RAP_SETS - 1)) begin
                        state <= st_run;
                    end
                end
                default: begin
                    state <= st_run;
                end
            endcase
        end
    end

    assign ready = (state == st_run);

    // lookup side, compare every way of the fetched set
    always_comb begin
        raw_hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `RAP_WAYS; w++) begin
            if (rd_a[w].valid && rd_a[w].tag == look_tag) begin
                raw_hit = 1'b1;
                hit_way = rap_pkg::way_t'(w);
            end
        end
    end

    // ram contents are garbage until the sweep is done
    assign hit = raw_hit && ready;

    // training side, skip bundles already recorded
    always_comb begin
        dup = 1'b0;
        for (int w = 0; w < `RAP_WAYS; w++) begin
            if (rd_b[w].valid && rd_b[w].tag == rec_tag) begin
                dup = 1'b1;
            end
        end
    end

    assign victim = plru[rec_idx];
    assign do_write = ready && record && !dup;

    always_comb begin
        merged = rd_b;
        merged[victim].valid = 1'b1;
        merged[victim].tag = rec_tag;
    end

    assign ram_we = !ready || do_write;
    assign ram_waddr = ready ? rec_idx : clr_idx;
    assign ram_wdata = ready ? merged : '0;

    // lookups are unqualified, so any hit on lookup_pc steers the lru
    // a write to the same set wins since it is assigned last
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            plru <= '0;
        end else begin
            if (hit) begin
                plru[look_idx] <= ~hit_way;
            end
            if (do_write) begin
                plru[rec_idx] <= ~victim;
            end
        end
    end

    meta_ram u_meta_ram (
        .clk     (clk),
        .we      (ram_we),
        .waddr   (ram_waddr),
        .wdata   (ram_wdata),
        .raddr_a (look_idx),
        .raddr_b (rec_idx),
        .rdata_a (rd_a),
        .rdata_b (rd_b)
    );

    // duplicate filter must keep tags unique within a set
    a_no_dup_tag: assert property (
        @(posedge clk) disable iff (!arst_n)
        ready |-> !(rd_a[0].valid && rd_a[1].valid && rd_a[0].tag == rd_a[1].tag)
    ) else $error("rpct: set %0d holds the same tag twice", look_idx);

endmodule

// File: src/meta_ram.sv
`timescale 1ns/100ps

`include "rap_cfg.svh"

module meta_ram (
    input logic clk,
    input logic we,
    input rap_pkg::index_t waddr,
    input rap_pkg::set_meta_t wdata,
    input rap_pkg::index_t raddr_a,
    input rap_pkg::index_t raddr_b,
    output rap_pkg::set_meta_t rdata_a,
    output rap_pkg::set_meta_t rdata_b
);

    // distributed ram, contents undefined until written
    rap_pkg::set_meta_t mem [`RAP_SETS];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // both read ports are asynchronous
    assign rdata_a = mem[raddr_a];
    assign rdata_b = mem[raddr_b];

    // an unknown write address would corrupt an arbitrary set
    a_waddr_known: assert property (
        @(posedge clk) we |-> !$isunknown(waddr)
    ) else $error("meta_ram: write with unknown address");

endmodule

// File: src/rap_pkg.sv
`include "rap_cfg.svh"

package rap_pkg;

    // fetch bundles are two instructions, 8 bytes
    localparam int OFFSET_W = 3;
    localparam int INDEX_W = $clog2(`RAP_SETS);
    localparam int TAG_W = `RAP_ADDR_W - OFFSET_W - INDEX_W;

    typedef logic [`RAP_ADDR_W-1:0] addr_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;
    typedef logic [$clog2(`RAP_WAYS)-1:0] way_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } meta_t;

    // one ram word holds every way of a set
    typedef meta_t [`RAP_WAYS-1:0] set_meta_t;

    typedef struct packed {
        logic valid;
        addr_t pc;
    } fetch_req_t;

    typedef enum logic [1:0] {
        train_none = 2'd0,
        train_call = 2'd1,
        train_ret = 2'd2
    } train_op_e;

    typedef struct packed {
        train_op_e op;
        addr_t pc;
    } train_t;

    typedef struct packed {
        logic valid;
        addr_t target;
    } pred_t;

    function automatic index_t bundle_index(addr_t pc);
        return pc[OFFSET_W +: INDEX_W];
    endfunction

    function automatic tag_t bundle_tag(addr_t pc);
        return pc[`RAP_ADDR_W-1 -: TAG_W];
    endfunction

endpackage

// File: src/rap_cfg.svh
`ifndef RAP_CFG_SVH
`define RAP_CFG_SVH

// width of a code address
`define RAP_ADDR_W 32

// return-pc cache table geometry
`define RAP_SETS 8
// pseudo-lru below is one bit per set, so this stays at 2
`define RAP_WAYS 2

// return address stack entries
`define RAP_RAS_DEPTH 8

`endif
